// ==== logic/pipe_pkg.sv ====
// core types for the five-stage pipeline
// four 16-bit registers, 8-bit immediate is zero-extended by load-immediate

package pipe_pkg;

    //////////////////////////////////////////////////////////////////////
    // sizes
    //////////////////////////////////////////////////////////////////////

    localparam int NUM_REGS  = 4;
    localparam int REG_IDX_W = $clog2(NUM_REGS);
    localparam int DATA_W    = 16;
    localparam int IMM_W     = 8;

    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [DATA_W-1:0]    data_t;
    typedef logic [IMM_W-1:0]     imm_t;

    typedef enum logic [2:0] {
        OP_NOP = 3'd0,
        OP_ADD = 3'd1,
        OP_SUB = 3'd2,
        OP_AND = 3'd3,
        OP_XOR = 3'd4,
        OP_LDI = 3'd5
    } opcode_t;

    //////////////////////////////////////////////////////////////////////
    // instruction, stage payloads and writeback
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        opcode_t  opcode;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        imm_t     imm;
    } instr_t;

    // ID/EX payload, operands already read from the register file
    typedef struct packed {
        opcode_t  op;
        reg_idx_t rd;
        data_t    a;
        data_t    b;
        imm_t     imm;
    } ex_reg_t;

    // EX/MEM and MEM/WB payload
    typedef struct packed {
        opcode_t  op;
        reg_idx_t rd;
        data_t    data;
    } res_reg_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        data_t    data;
    } wb_t;

endpackage

// ==== logic/trace_pkg.sv ====
// trace record layout, stage status seen by the tracker, FIFO and APB map
// FIFO depth must be a power of two, pointers wrap without compare

package trace_pkg;

    typedef logic [7:0]  seq_t;
    typedef logic [15:0] cycle_t;
    typedef logic [3:0]  stall_cnt_t;

    // where each instruction sits this cycle, as reported by the core
    typedef struct packed {
        logic               id_valid;
        logic               ex_valid;
        logic               mem_valid;
        logic               wb_valid;
        logic               stall;
        logic               accept;
        pipe_pkg::opcode_t  wb_op;
        pipe_pkg::reg_idx_t wb_rd;
    } stage_status_t;

    // one retired instruction, stall count saturates
    typedef struct packed {
        seq_t               seq;
        pipe_pkg::opcode_t  op;
        pipe_pkg::reg_idx_t rd;
        stall_cnt_t         stalls;
        cycle_t             issue;
        cycle_t             retire;
    } trace_rec_t;

    localparam int TRACE_DEPTH = 8;
    localparam int TRACE_PTR_W = $clog2(TRACE_DEPTH);
    localparam int TRACE_CNT_W = $clog2(TRACE_DEPTH + 1);

    //////////////////////////////////////////////////////////////////////
    // APB map
    //////////////////////////////////////////////////////////////////////

    localparam logic [3:0] REG_STATUS   = 4'h0;
    localparam logic [3:0] REG_TRACE_LO = 4'h4;
    localparam logic [3:0] REG_TRACE_HI = 4'h8;

    // STATUS: count in the low bits, sticky overflow here (write 1 to clear)
    localparam int STATUS_OVF_BIT = 16;

endpackage

// ==== logic/pipe_core.sv ====
`timescale 1ns/1ps
// no forwarding, a RAW hazard holds decode until the producer reaches WB
// register file is written at the end of WB and bypassed to decode in that cycle

module pipe_core (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     instr_valid,
    input  pipe_pkg::instr_t         instr,
    output logic                     instr_ready,
    output pipe_pkg::wb_t            wb,
    output trace_pkg::stage_status_t stage_status
);
    import pipe_pkg::*;

    logic     id_valid;
    logic     ex_valid;
    logic     mem_valid;
    logic     wb_valid;
    instr_t   id_instr;
    ex_reg_t  ex_reg;
    res_reg_t mem_reg;
    res_reg_t wb_reg;
    data_t    rf [NUM_REGS];
    data_t    rs1_val;
    data_t    rs2_val;
    data_t    alu_out;
    logic     stall;
    logic     accept;

    function automatic logic writes_rd(opcode_t op);
        return op != OP_NOP;
    endfunction

    function automatic logic reads_src(opcode_t op);
        return op inside {OP_ADD, OP_SUB, OP_AND, OP_XOR};
    endfunction

    // true if a valid writer in a later stage targets one of our sources
    function automatic logic raw_hit(instr_t ins, logic v, opcode_t op, reg_idx_t rd);
        return v && writes_rd(op) && reads_src(ins.opcode) &&
               (rd == ins.rs1 || rd == ins.rs2);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // hazard interlock
    //////////////////////////////////////////////////////////////////////

    assign stall = id_valid &&
                   (raw_hit(id_instr, ex_valid, ex_reg.op, ex_reg.rd) ||
                    raw_hit(id_instr, mem_valid, mem_reg.op, mem_reg.rd));

    assign instr_ready = !stall;
    assign accept      = instr_valid && instr_ready;

    // write-through read, WB result wins over the stored value
    assign rs1_val = (wb.valid && wb.rd == id_instr.rs1) ? wb.data : rf[id_instr.rs1];
    assign rs2_val = (wb.valid && wb.rd == id_instr.rs2) ? wb.data : rf[id_instr.rs2];

    always_comb begin
        case (ex_reg.op)
            OP_ADD:  alu_out = ex_reg.a + ex_reg.b;
            OP_SUB:  alu_out = ex_reg.a - ex_reg.b;
            OP_AND:  alu_out = ex_reg.a & ex_reg.b;
            OP_XOR:  alu_out = ex_reg.a ^ ex_reg.b;
            OP_LDI:  alu_out = {{(DATA_W - IMM_W){1'b0}}, ex_reg.imm};
            default: alu_out = '0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // stage registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            id_valid  <= 1'b0;
            ex_valid  <= 1'b0;
            mem_valid <= 1'b0;
            wb_valid  <= 1'b0;
        end else begin
            // IF/ID freezes on a stall, a bubble goes to EX instead
            if (!stall) begin
                id_valid <= instr_valid;
            end
            ex_valid  <= id_valid && !stall;
            mem_valid <= ex_valid;
            wb_valid  <= mem_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            id_instr <= instr;
        end
        ex_reg  <= '{op: id_instr.opcode, rd: id_instr.rd, a: rs1_val, b: rs2_val,
                     imm: id_instr.imm};
        mem_reg <= '{op: ex_reg.op, rd: ex_reg.rd, data: alu_out};
        // memory stage only carries the result
        wb_reg  <= mem_reg;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                rf[i] <= '0;
            end
        end else if (wb.valid) begin
            rf[wb.rd] <= wb.data;
        end
    end

    // nop reaches WB but writes nothing
    assign wb = '{valid: wb_valid && writes_rd(wb_reg.op), rd: wb_reg.rd, data: wb_reg.data};

    assign stage_status = '{id_valid: id_valid, ex_valid: ex_valid, mem_valid: mem_valid,
                            wb_valid: wb_valid, stall: stall, accept: accept,
                            wb_op: wb_reg.op, wb_rd: wb_reg.rd};

endmodule

// ==== logic/stage_tracker.sv ====
`timescale 1ns/1ps
// follows instructions using the core's stage valid bits, no hazard logic of its own
// cycle stamps wrap at 16 bits, stall count saturates at 15

module stage_tracker (
    input  logic                     clk,
    input  logic                     rst,
    input  trace_pkg::stage_status_t stage_status,
    output logic                     rec_push,
    output trace_pkg::trace_rec_t    rec
);
    import trace_pkg::*;

    // per-stage tag riding alongside the instruction
    typedef struct packed {
        seq_t       seq;
        cycle_t     issue;
        stall_cnt_t stalls;
    } tag_t;

    seq_t   next_seq;
    cycle_t cycle;
    tag_t   id_tag;
    tag_t   ex_tag;
    tag_t   mem_tag;
    tag_t   wb_tag;

    //////////////////////////////////////////////////////////////////////
    // counters
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cycle    <= '0;
            next_seq <= '0;
        end else begin
            cycle <= cycle + 1'b1;
            if (stage_status.accept) begin
                next_seq <= next_seq + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // tag pipeline
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        // stamp on acceptance, otherwise count cycles held in decode
        if (stage_status.accept) begin
            id_tag <= '{seq: next_seq, issue: cycle, stalls: '0};
        end else if (stage_status.stall && id_tag.stalls != '1) begin
            id_tag.stalls <= id_tag.stalls + 1'b1;
        end

        // tags move only where a real instruction moves
        if (stage_status.id_valid && !stage_status.stall) begin
            ex_tag <= id_tag;
        end
        if (stage_status.ex_valid) begin
            mem_tag <= ex_tag;
        end
        if (stage_status.mem_valid) begin
            wb_tag <= mem_tag;
        end
    end

    // record leaves in the WB cycle, retire stamp is that cycle
    assign rec_push = stage_status.wb_valid;

    assign rec = '{seq: wb_tag.seq, op: stage_status.wb_op, rd: stage_status.wb_rd,
                   stalls: wb_tag.stalls, issue: wb_tag.issue, retire: cycle};

endmodule

// ==== logic/trace_apb_regs.sv ====
`timescale 1ns/1ps
// zero-wait APB, records pushed into a full FIFO are dropped and flag overflow
// TRACE_LO peeks at the head record, TRACE_HI returns the stamps and pops

module trace_apb_regs (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rec_push,
    input  trace_pkg::trace_rec_t rec,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [3:0]            paddr,
    input  logic [31:0]           pwdata,
    output logic [31:0]           prdata,
    output logic                  pready
);
    import trace_pkg::*;

    trace_rec_t             fifo [TRACE_DEPTH];
    trace_rec_t             head;
    logic [TRACE_PTR_W-1:0] wr_ptr;
    logic [TRACE_PTR_W-1:0] rd_ptr;
    logic [TRACE_CNT_W-1:0] count;
    logic                   ovf;
    logic                   full;
    logic                   empty;
    logic                   rd_access;
    logic                   wr_access;
    logic                   pop;
    logic                   push;
    logic                   ovf_clr;

    assign pready    = 1'b1;
    assign rd_access = psel && penable && !pwrite;
    assign wr_access = psel && penable && pwrite;

    assign full  = (count == TRACE_CNT_W'(TRACE_DEPTH));
    assign empty = (count == '0);
    assign head  = fifo[rd_ptr];

    assign pop     = rd_access && paddr == REG_TRACE_HI && !empty;
    // a pop in the same cycle frees the slot for the incoming record
    assign push    = rec_push && (!full || pop);
    assign ovf_clr = wr_access && paddr == REG_STATUS && pwdata[STATUS_OVF_BIT];

    //////////////////////////////////////////////////////////////////////
    // FIFO control
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            ovf    <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // a drop in the same cycle as a clear keeps the flag set
            if (rec_push && !push) begin
                ovf <= 1'b1;
            end else if (ovf_clr) begin
                ovf <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            fifo[wr_ptr] <= rec;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read mux
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        prdata = '0;
        if (rd_access) begin
            case (paddr)
                REG_STATUS: begin
                    prdata[TRACE_CNT_W-1:0] = count;
                    prdata[STATUS_OVF_BIT]  = ovf;
                end
                // seq[16:9] op[8:6] rd[5:4] stalls[3:0]
                REG_TRACE_LO: if (!empty) prdata = 32'({head.seq, head.op, head.rd, head.stalls});
                // retire[31:16] issue[15:0]
                REG_TRACE_HI: if (!empty) prdata = {head.retire, head.issue};
                default: prdata = '0;
            endcase
        end
    end

endmodule

// ==== logic/traced_pipe_top.sv ====
`timescale 1ns/1ps
// pipeline with hardware trace, records read back over APB
// instruction source must hold instr while instr_ready is low

module traced_pipe_top (
    input  logic             clk,
    input  logic             rst,
    input  logic             instr_valid,
    input  pipe_pkg::instr_t instr,
    output logic             instr_ready,
    output pipe_pkg::wb_t    wb,
    input  logic             psel,
    input  logic             penable,
    input  logic             pwrite,
    input  logic [3:0]       paddr,
    input  logic [31:0]      pwdata,
    output logic [31:0]      prdata,
    output logic             pready
);
    import trace_pkg::*;

    stage_status_t stage_status;
    logic          rec_push;
    trace_rec_t    rec;

    pipe_core u_pipe_core (
        .clk          (clk),
        .rst          (rst),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .instr_ready  (instr_ready),
        .wb           (wb),
        .stage_status (stage_status)
    );

    stage_tracker u_stage_tracker (
        .clk          (clk),
        .rst          (rst),
        .stage_status (stage_status),
        .rec_push     (rec_push),
        .rec          (rec)
    );

    trace_apb_regs u_trace_apb_regs (
        .clk      (clk),
        .rst      (rst),
        .rec_push (rec_push),
        .rec      (rec),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready)
    );

endmodule

// ==== test/traced_pipe_tb.sv ====
`timescale 1ns/1ps
// back-to-back table, then an LFSR random phase that overruns the trace FIFO
// instr_valid stays high within a phase and the trace FIFO is drained over APB after each

module traced_pipe_tb;
    import pipe_pkg::*;
    import trace_pkg::*;

    localparam int TABLE_LEN = 8;
    localparam int RAND_LEN  = 12;
    localparam int MAX_INSTR = TABLE_LEN + RAND_LEN;
    localparam int CYCLE_LIMIT = (TABLE_LEN + RAND_LEN) * 8 + 200;

    typedef struct packed {
        instr_t     ins;
        data_t      exp_val;
        logic [3:0] exp_stalls;
    } row_t;

    logic        clk;
    logic        rst;
    logic        instr_valid;
    instr_t      instr;
    logic        instr_ready;
    wb_t         wb;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;

    row_t        prog [TABLE_LEN];
    logic [15:0] cyc;
    int          run_cycles;
    logic [31:0] lfsr;

    // reference model state indexed by sequence number
    data_t       mrf [NUM_REGS];
    opcode_t     m_op [MAX_INSTR];
    reg_idx_t    m_rd [MAX_INSTR];
    data_t       m_data [MAX_INSTR];
    int          m_issue [MAX_INSTR];
    int          m_stalls [MAX_INSTR];
    int          m_retire [MAX_INSTR];
    int          m_ex [MAX_INSTR];
    int          n_acc;
    int          last_retire;
    int          wb_q [$];

    traced_pipe_top u_traced_pipe_top (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_ready (instr_ready),
        .wb          (wb),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // own cycle stamp that starts at 0 after reset
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            cyc <= '0;
        end else begin
            cyc <= cyc + 16'd1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // failure reporting
    //////////////////////////////////////////////////////////////////////

    task automatic abort_run();
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        assert (got == exp) else begin
            $display("FAILED at %0t: %s got %0h expected %0h", $time, name, got, exp);
            abort_run();
        end
    endtask

    always @(posedge clk) begin
        run_cycles = run_cycles + 1;
        if (run_cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            abort_run();
        end
    end

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    function automatic row_t make_row(opcode_t op, reg_idx_t rd, reg_idx_t rs1,
                                      reg_idx_t rs2, imm_t imm, data_t val, int stalls);
        row_t r;
        r.ins.opcode = op;
        r.ins.rd     = rd;
        r.ins.rs1    = rs1;
        r.ins.rs2    = rs2;
        r.ins.imm    = imm;
        r.exp_val    = val;
        r.exp_stalls = 4'(stalls);
        return r;
    endfunction

    // leaves ID once no dependent writer sits in EX or MEM
    task automatic model_accept(input instr_t ins, input int issue);
        int    ex;
        int    j;
        int    s;
        data_t a;
        data_t b;
        data_t res;
        s  = n_acc;
        ex = issue + 2;
        if (ins.opcode inside {OP_ADD, OP_SUB, OP_AND, OP_XOR}) begin
            for (j = 0; j < s; j++) begin
                if (m_op[j] != OP_NOP && (m_rd[j] == ins.rs1 || m_rd[j] == ins.rs2) &&
                    m_ex[j] + 3 > ex) begin
                    ex = m_ex[j] + 3;
                end
            end
        end
        a = mrf[ins.rs1];
        b = mrf[ins.rs2];
        case (ins.opcode)
            OP_ADD:  res = a + b;
            OP_SUB:  res = a - b;
            OP_AND:  res = a & b;
            OP_XOR:  res = a ^ b;
            OP_LDI:  res = {8'h00, ins.imm};
            default: res = '0;
        endcase
        m_op[s]     = ins.opcode;
        m_rd[s]     = ins.rd;
        m_data[s]   = res;
        m_issue[s]  = issue;
        m_ex[s]     = ex;
        m_stalls[s] = ex - issue - 2;
        m_retire[s] = ex + 2;
        if (ins.opcode != OP_NOP) begin
            mrf[ins.rd] = res;
            wb_q.push_back(s);
        end
        last_retire = ex + 2;
        n_acc++;
    endtask

    // writebacks must come in program order at the predicted cycle
    always @(negedge clk) begin
        int s;
        if (!rst && wb.valid) begin
            assert (wb_q.size() > 0) else begin
                $display("a writeback appeared with no instruction outstanding");
                abort_run();
            end
            s = wb_q.pop_front();
            check_eq("wb.rd", 32'(wb.rd), 32'(m_rd[s]));
            check_eq("wb.data", 32'(wb.data), 32'(m_data[s]));
            check_eq("wb retire cycle", 32'(cyc), 32'(m_retire[s]));
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers entered 1 ns after a rising edge
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] next_lfsr(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr = next_lfsr(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic send_instr(input instr_t ins);
        logic accepted;
        accepted    = 1'b0;
        instr_valid = 1'b1;
        instr       = ins;
        while (!accepted) begin
            @(negedge clk);
            if (instr_ready) begin
                accepted = 1'b1;
                model_accept(ins, int'(cyc));
            end
            @(posedge clk);
            #1;
        end
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] data);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        check_eq("pready", 32'(pready), 32'd1);
        data = prdata;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic wait_drain();
        while (int'(cyc) <= last_retire) begin
            @(posedge clk);
            #1;
        end
        assert (wb_q.size() == 0) else begin
            $display("pipeline drained but %0d writebacks never appeared", wb_q.size());
            abort_run();
        end
    endtask

    // TRACE_LO layout seq[16:9] op[8:6] rd[5:4] stalls[3:0] and TRACE_HI retire:issue
    task automatic read_record(input int s);
        logic [31:0] lo;
        logic [31:0] hi;
        logic [15:0] span;
        apb_read(REG_TRACE_LO, lo);
        apb_read(REG_TRACE_HI, hi);
        span = hi[31:16] - hi[15:0];
        check_eq("trace retire-issue", 32'(span), 32'(4 + m_stalls[s]));
        check_eq("trace seq", 32'(lo[16:9]), 32'(8'(s)));
        check_eq("trace op", 32'(lo[8:6]), 32'(m_op[s]));
        check_eq("trace rd", 32'(lo[5:4]), 32'(m_rd[s]));
        check_eq("trace stalls", 32'(lo[3:0]), 32'(m_stalls[s]));
        check_eq("trace issue", 32'(hi[15:0]), 32'(m_issue[s]));
        check_eq("trace retire", 32'(hi[31:16]), 32'(m_retire[s]));
    endtask

    task automatic drain_records(input int first, input int n, input logic ovf);
        logic [31:0] st;
        int          k;
        for (k = 0; k < n; k++) begin
            apb_read(REG_STATUS, st);
            check_eq("STATUS count", 32'(st[15:0]), 32'(n - k));
            check_eq("STATUS overflow", 32'(st[STATUS_OVF_BIT]), 32'(ovf));
            read_record(first + k);
        end
        apb_read(REG_STATUS, st);
        check_eq("STATUS count", 32'(st[15:0]), 32'd0);
        apb_read(REG_TRACE_LO, st);
        check_eq("prdata TRACE_LO empty", st, 32'd0);
        apb_read(REG_TRACE_HI, st);
        check_eq("prdata TRACE_HI empty", st, 32'd0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        instr_t      ins;
        logic [31:0] v;
        logic [31:0] st;
        int          i;

        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        run_cycles  = 0;
        lfsr        = 32'hd5f5_37ba;
        n_acc       = 0;
        last_retire = 0;
        for (i = 0; i < NUM_REGS; i++) begin
            mrf[i] = '0;
        end

        // independent loads, then RAW at distance two and one, then a nop gap
        prog[0] = make_row(OP_LDI, 2'd0, 2'd0, 2'd0, 8'h12, 16'h0012, 0);
        prog[1] = make_row(OP_LDI, 2'd1, 2'd0, 2'd0, 8'h34, 16'h0034, 0);
        prog[2] = make_row(OP_LDI, 2'd2, 2'd0, 2'd0, 8'h0f, 16'h000f, 0);
        prog[3] = make_row(OP_ADD, 2'd3, 2'd0, 2'd1, 8'h00, 16'h0046, 1);
        prog[4] = make_row(OP_SUB, 2'd3, 2'd3, 2'd2, 8'h00, 16'h0037, 2);
        prog[5] = make_row(OP_XOR, 2'd0, 2'd0, 2'd2, 8'h00, 16'h001d, 0);
        prog[6] = make_row(OP_NOP, 2'd0, 2'd0, 2'd0, 8'h00, 16'h0000, 0);
        prog[7] = make_row(OP_AND, 2'd1, 2'd0, 2'd3, 8'h00, 16'h0015, 1);

        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        for (i = 0; i < TABLE_LEN; i++) begin
            send_instr(prog[i].ins);
            if (prog[i].ins.opcode != OP_NOP) begin
                check_eq("table value", 32'(m_data[i]), 32'(prog[i].exp_val));
            end
            check_eq("table stall count", 32'(m_stalls[i]), 32'(prog[i].exp_stalls));
        end
        instr_valid = 1'b0;
        wait_drain();
        drain_records(0, TABLE_LEN, 1'b0);

        // random phase retires more than the FIFO holds
        for (i = 0; i < RAND_LEN; i++) begin
            take_bits(3, v);
            ins.opcode = opcode_t'(3'(v % 6));
            take_bits(2, v);
            ins.rd = 2'(v);
            take_bits(2, v);
            ins.rs1 = 2'(v);
            take_bits(2, v);
            ins.rs2 = 2'(v);
            take_bits(8, v);
            ins.imm = 8'(v);
            send_instr(ins);
        end
        instr_valid = 1'b0;
        wait_drain();
        drain_records(TABLE_LEN, TRACE_DEPTH, 1'b1);

        apb_write(REG_STATUS, 32'd1 << STATUS_OVF_BIT);
        apb_read(REG_STATUS, st);
        check_eq("STATUS after clear", st, 32'd0);

        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== traced_pipe.f ====
logic/pipe_pkg.sv
logic/trace_pkg.sv
logic/pipe_core.sv
logic/stage_tracker.sv
logic/trace_apb_regs.sv
logic/traced_pipe_top.sv
test/traced_pipe_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds and runs the testbench with Verilator, exit status is the result
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f traced_pipe.f \
    --top-module traced_pipe_tb \
    -o traced_pipe_sim

./obj_dir/traced_pipe_sim
